//--- aluPkg.sv
// word width default 32 and must be a multiple of GROUP_WIDTH; the opcode set has no mul, div or arithmetic shift
package aluPkg;

    // default word width, overridden through the top level parameter
    localparam int DATA_WIDTH = 32;

    // lookahead group width; claGroup equations are hand written for 8 bits
    localparam int GROUP_WIDTH = 8;

    // word type at the default width, handy for checkers and models
    typedef logic [DATA_WIDTH-1:0] wordT;

    // shift amount width for a given word width
    function automatic int shiftWidthOf(input int width);
        return $clog2(width);
    endfunction

    // shift amount width at the default word width
    localparam int SHIFT_WIDTH = shiftWidthOf(DATA_WIDTH);

    // operation codes
    // the first three go through the adder, the rest through logicUnit
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_ADC = 3'd1,
        OP_SUB = 3'd2,
        OP_AND = 3'd3,
        OP_OR  = 3'd4,
        OP_XOR = 3'd5,
        OP_SHL = 3'd6,
        OP_SHR = 3'd7
    } aluOpT;

endpackage

//--- flagPkg.sv
// flag order inside flagVecT is fixed by the FLAG_* indices; carry is a carry, never a borrow
package flagPkg;

    // number of status flags
    localparam int FLAG_COUNT = 4;

    // packed flag vector, indexed with the constants below
    typedef logic [FLAG_COUNT-1:0] flagVecT;

    // carry out of the top bit
    localparam int FLAG_C = 0;
    // signed overflow
    localparam int FLAG_V = 1;
    // result is all zeros
    localparam int FLAG_Z = 2;
    // top bit of the result
    localparam int FLAG_N = 3;

endpackage

//--- claGroup.sv
// fixed 8-bit lookahead slice, purely combinational; wider words chain several of these
`timescale 1ns/1ps

module claGroup (
    input  logic [aluPkg::GROUP_WIDTH-1:0] a,
    input  logic [aluPkg::GROUP_WIDTH-1:0] b,
    input  logic                           carryIn,
    output logic [aluPkg::GROUP_WIDTH-1:0] sum,
    output logic                           carryOut,
    output logic                           carryTop
);
    import aluPkg::*;

    // generate and propagate per bit
    logic [GROUP_WIDTH-1:0] g;
    logic [GROUP_WIDTH-1:0] p;
    // c[i] is the carry into bit i, c[8] leaves the group
    logic [GROUP_WIDTH:0]   c;

    assign g = a & b;
    // or-form propagate is fine here since the sum uses xor directly
    assign p = a | b;

    // two-level lookahead, every carry straight from g, p and carryIn
    assign c[0] = carryIn;
    assign c[1] = g[0] | (p[0] & c[0]);
    assign c[2] = g[1] | (p[1] & g[0]) | (&p[1:0] & c[0]);
    assign c[3] = g[2] | (p[2] & g[1]) | (&p[2:1] & g[0]) | (&p[2:0] & c[0]);
    assign c[4] = g[3] | (p[3] & g[2]) | (&p[3:2] & g[1]) | (&p[3:1] & g[0])
                | (&p[3:0] & c[0]);
    assign c[5] = g[4] | (p[4] & g[3]) | (&p[4:3] & g[2]) | (&p[4:2] & g[1])
                | (&p[4:1] & g[0]) | (&p[4:0] & c[0]);
    assign c[6] = g[5] | (p[5] & g[4]) | (&p[5:4] & g[3]) | (&p[5:3] & g[2])
                | (&p[5:2] & g[1]) | (&p[5:1] & g[0]) | (&p[5:0] & c[0]);
    assign c[7] = g[6] | (p[6] & g[5]) | (&p[6:5] & g[4]) | (&p[6:4] & g[3])
                | (&p[6:3] & g[2]) | (&p[6:2] & g[1]) | (&p[6:1] & g[0])
                | (&p[6:0] & c[0]);
    assign c[8] = g[7] | (p[7] & g[6]) | (&p[7:6] & g[5]) | (&p[7:5] & g[4])
                | (&p[7:4] & g[3]) | (&p[7:3] & g[2]) | (&p[7:2] & g[1])
                | (&p[7:1] & g[0]) | (&p[7:0] & c[0]);

    assign sum = a ^ b ^ c[GROUP_WIDTH-1:0];

    // carry out of bit 7 goes to the next group
    assign carryOut = c[GROUP_WIDTH];
    // carry into bit 7, needed for overflow at the top group
    assign carryTop = c[GROUP_WIDTH-1];

endmodule

//--- addSubUnit.sv
// combinational add, adc and sub; DATA_WIDTH must be a multiple of 8, carry out is not a borrow
`timescale 1ns/1ps

module addSubUnit #(
    parameter int DATA_WIDTH = aluPkg::DATA_WIDTH
) (
    input  logic [DATA_WIDTH-1:0] opA,
    input  logic [DATA_WIDTH-1:0] opB,
    input  aluPkg::aluOpT         opCode,
    input  logic                  storedCarry,
    output logic [DATA_WIDTH-1:0] sum,
    output logic                  sumCarry,
    output logic                  sumOverflow
);
    import aluPkg::*;

    localparam int NUM_GROUPS = DATA_WIDTH / GROUP_WIDTH;

    // second operand after conditioning for subtract
    logic [DATA_WIDTH-1:0] bOperand;
    // carry into the whole adder
    logic                  carryIn;
    // ripple carries between groups, index 0 is the adder carry-in
    logic [NUM_GROUPS:0]   groupCarry;
    // carry into bit 7 of each group, only the top one matters
    logic [NUM_GROUPS-1:0] groupTop;

    // catch an unsupported width at elaboration
    if (DATA_WIDTH % GROUP_WIDTH != 0) begin : gWidthCheck
        $error("addSubUnit DATA_WIDTH must be a multiple of GROUP_WIDTH");
    end

    // subtract is A + ~B + 1
    assign bOperand = (opCode == OP_SUB) ? ~opB : opB;

    // carry-in per opcode
    always_comb begin
        unique case (opCode)
            OP_SUB:  carryIn = 1'b1;
            // adc takes the flag left by the previous op
            OP_ADC:  carryIn = storedCarry;
            default: carryIn = 1'b0;
        endcase
    end

    assign groupCarry[0] = carryIn;

    // one lookahead group per byte, carries ripple upward
    for (genvar gi = 0; gi < NUM_GROUPS; gi++) begin : gGroup
        claGroup i_claGroup (
            .a        (opA[gi*GROUP_WIDTH +: GROUP_WIDTH]),
            .b        (bOperand[gi*GROUP_WIDTH +: GROUP_WIDTH]),
            .carryIn  (groupCarry[gi]),
            .sum      (sum[gi*GROUP_WIDTH +: GROUP_WIDTH]),
            .carryOut (groupCarry[gi+1]),
            .carryTop (groupTop[gi])
        );
    end

    // carry out of the msb
    assign sumCarry = groupCarry[NUM_GROUPS];

    // signed overflow when carry into and out of the msb differ
    assign sumOverflow = groupTop[NUM_GROUPS-1] ^ groupCarry[NUM_GROUPS];

endmodule

//--- logicUnit.sv
// combinational bitwise ops and logical shifts only; shift amount is the low log2(DATA_WIDTH) bits of opB
`timescale 1ns/1ps

module logicUnit #(
    parameter int DATA_WIDTH = aluPkg::DATA_WIDTH
) (
    input  logic [DATA_WIDTH-1:0] opA,
    input  logic [DATA_WIDTH-1:0] opB,
    input  aluPkg::aluOpT         opCode,
    output logic [DATA_WIDTH-1:0] logicResult
);
    import aluPkg::*;

    localparam int SHIFT_BITS = shiftWidthOf(DATA_WIDTH);

    // shift distance, upper bits of opB are ignored
    logic [SHIFT_BITS-1:0] shiftAmount;

    assign shiftAmount = opB[SHIFT_BITS-1:0];

    always_comb begin
        unique case (opCode)
            OP_AND: begin
                logicResult = opA & opB;
            end
            OP_OR: begin
                logicResult = opA | opB;
            end
            OP_XOR: begin
                logicResult = opA ^ opB;
            end
            // zeros shift in from the right
            OP_SHL: begin
                logicResult = opA << shiftAmount;
            end
            // zeros shift in from the left, no sign fill
            OP_SHR: begin
                logicResult = opA >> shiftAmount;
            end
            // arithmetic codes belong to addSubUnit
            default: begin
                logicResult = '0;
            end
        endcase
    end

endmodule

//--- resultStage.sv
// one register stage; result holds until the next opValid, resValid is a single-cycle strobe
`timescale 1ns/1ps

module resultStage #(
    parameter int DATA_WIDTH = aluPkg::DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  opValid,
    input  aluPkg::aluOpT         opCode,
    input  logic [DATA_WIDTH-1:0] sum,
    input  logic                  sumCarry,
    input  logic                  sumOverflow,
    input  logic [DATA_WIDTH-1:0] logicResult,
    output flagPkg::flagVecT      flagsNext,
    output logic                  resValid,
    output logic [DATA_WIDTH-1:0] result
);
    import aluPkg::*;
    import flagPkg::*;

    // op goes through the adder
    logic                  isArith;
    // word that will be registered
    logic [DATA_WIDTH-1:0] selected;

    assign isArith = opCode inside {OP_ADD, OP_ADC, OP_SUB};

    assign selected = isArith ? sum : logicResult;

    // next flags, statusReg decides whether to load them
    always_comb begin
        flagsNext         = '0;
        // logic and shift ops report no carry or overflow
        flagsNext[FLAG_C] = isArith & sumCarry;
        flagsNext[FLAG_V] = isArith & sumOverflow;
        flagsNext[FLAG_Z] = ~|selected;
        flagsNext[FLAG_N] = selected[DATA_WIDTH-1];
    end

    // valid strobe follows opValid by one cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resValid <= 1'b0;
        end else begin
            resValid <= opValid;
        end
    end

    // result only changes on a new operation
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result <= '0;
        end else if (opValid) begin
            result <= selected;
        end
    end

    // an x on an operand or opcode must not reach a valid result
    aResultKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        resValid |-> !$isunknown(result)
    ) else $error("resultStage: valid result holds unknown bits");

endmodule

//--- statusReg.sv
// flags load on opValid and clear on flagsClear; an op in the same cycle as a clear wins
`timescale 1ns/1ps

module statusReg (
    input  logic             clk,
    input  logic             arstN,
    input  logic             opValid,
    input  logic             flagsClear,
    input  flagPkg::flagVecT flagsNext,
    output logic             carry,
    output logic             overflow,
    output logic             zero,
    output logic             negative,
    output logic             storedCarry
);
    import flagPkg::*;

    // the status register itself
    flagVecT flags;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flags <= '0;
        end else if (opValid) begin
            flags <= flagsNext;
        end else if (flagsClear) begin
            flags <= '0;
        end
    end

    assign carry    = flags[FLAG_C];
    assign overflow = flags[FLAG_V];
    assign zero     = flags[FLAG_Z];
    assign negative = flags[FLAG_N];

    // fed back to the adder for the next adc, same edge as the result
    assign storedCarry = flags[FLAG_C];

    // a lone clear strobe must leave nothing behind
    aClearFlags: assert property (
        @(posedge clk) disable iff (!arstN)
        (flagsClear && !opValid) |=> (flags == '0)
    ) else $error("statusReg: flags not cleared after flagsClear");

endmodule

//--- aluTop.sv
// one-cycle execute stage, no handshake or back-pressure; DATA_WIDTH must be a multiple of 8
`timescale 1ns/1ps

module aluTop #(
    parameter int DATA_WIDTH = aluPkg::DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  opValid,
    input  aluPkg::aluOpT         opCode,
    input  logic [DATA_WIDTH-1:0] opA,
    input  logic [DATA_WIDTH-1:0] opB,
    input  logic                  flagsClear,
    output logic                  resValid,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  carry,
    output logic                  overflow,
    output logic                  zero,
    output logic                  negative
);
    import flagPkg::*;

    // adder outputs
    logic [DATA_WIDTH-1:0] sum;
    logic                  sumCarry;
    logic                  sumOverflow;
    // logic and shift output
    logic [DATA_WIDTH-1:0] logicResult;
    // flags for the op in flight
    flagVecT               flagsNext;
    // carry flag looped back for adc
    logic                  storedCarry;

    addSubUnit #(.DATA_WIDTH(DATA_WIDTH)) i_addSubUnit (
        .opA         (opA),
        .opB         (opB),
        .opCode      (opCode),
        .storedCarry (storedCarry),
        .sum         (sum),
        .sumCarry    (sumCarry),
        .sumOverflow (sumOverflow)
    );

    logicUnit #(.DATA_WIDTH(DATA_WIDTH)) i_logicUnit (
        .opA         (opA),
        .opB         (opB),
        .opCode      (opCode),
        .logicResult (logicResult)
    );

    resultStage #(.DATA_WIDTH(DATA_WIDTH)) i_resultStage (
        .clk         (clk),
        .arstN       (arstN),
        .opValid     (opValid),
        .opCode      (opCode),
        .sum         (sum),
        .sumCarry    (sumCarry),
        .sumOverflow (sumOverflow),
        .logicResult (logicResult),
        .flagsNext   (flagsNext),
        .resValid    (resValid),
        .result      (result)
    );

    statusReg i_statusReg (
        .clk         (clk),
        .arstN       (arstN),
        .opValid     (opValid),
        .flagsClear  (flagsClear),
        .flagsNext   (flagsNext),
        .carry       (carry),
        .overflow    (overflow),
        .zero        (zero),
        .negative    (negative),
        .storedCarry (storedCarry)
    );

endmodule

//--- tbAlu.sv
// runs at the package default width only; corner values and the model assume DATA_WIDTH is a multiple of 8
`timescale 1ns/1ps

module tbAlu;
    import aluPkg::*;
    import flagPkg::*;

    localparam int NUM_GROUPS = DATA_WIDTH / GROUP_WIDTH;

    logic    clk;
    logic    arstN;
    logic    opValid;
    aluOpT   opCode;
    wordT    opA;
    wordT    opB;
    logic    flagsClear;
    logic    resValid;
    wordT    result;
    logic    carry;
    logic    overflow;
    logic    zero;
    logic    negative;

    // scoreboard of issued operations, oldest first
    wordT    expWordQ[$];
    flagVecT expFlagQ[$];
    int      issueCycQ[$];

    // carry as the model sees it after the last op or clear
    logic    modelCarry;
    int      cycleCount;
    int      issuedOps;
    int      mismatchErrors;
    int      protocolErrors;
    int      timeoutErrors;
    wordT    cornerQ[$];
    aluOpT   opTable[8];

    aluTop #(.DATA_WIDTH(DATA_WIDTH)) i_aluTop (
        .clk        (clk),
        .arstN      (arstN),
        .opValid    (opValid),
        .opCode     (opCode),
        .opA        (opA),
        .opB        (opB),
        .flagsClear (flagsClear),
        .resValid   (resValid),
        .result     (result),
        .carry      (carry),
        .overflow   (overflow),
        .zero       (zero),
        .negative   (negative)
    );

    // 40 ns period
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // expected word and flags straight from the arithmetic rules
    function automatic void expectedOp(input aluOpT op, input wordT a, input wordT b,
                                       input logic cIn, output wordT res,
                                       output flagVecT flags);
        logic [DATA_WIDTH:0] wide;
        wordT                bEff;
        logic                cEff;
        logic                arith;
        bEff  = b;
        cEff  = 1'b0;
        arith = 1'b1;
        res   = '0;
        flags = '0;
        case (op)
            OP_ADC: cEff = cIn;
            // two's complement subtract, carry is not a borrow
            OP_SUB: begin
                bEff = ~b;
                cEff = 1'b1;
            end
            OP_ADD: cEff = 1'b0;
            default: arith = 1'b0;
        endcase
        case (op)
            OP_AND: res = a & b;
            OP_OR:  res = a | b;
            OP_XOR: res = a ^ b;
            OP_SHL: res = a << b[SHIFT_WIDTH-1:0];
            OP_SHR: res = a >> b[SHIFT_WIDTH-1:0];
            default: res = '0;
        endcase
        if (arith) begin
            wide = {1'b0, a} + {1'b0, bEff} + {{DATA_WIDTH{1'b0}}, cEff};
            res = wide[DATA_WIDTH-1:0];
            flags[FLAG_C] = wide[DATA_WIDTH];
            // same-sign operands giving a result of the other sign
            flags[FLAG_V] = (a[DATA_WIDTH-1] == bEff[DATA_WIDTH-1])
                          && (res[DATA_WIDTH-1] != a[DATA_WIDTH-1]);
        end
        flags[FLAG_Z] = (res == '0);
        flags[FLAG_N] = res[DATA_WIDTH-1];
    endfunction

    task automatic compareWord(input wordT got, input wordT exp, input string what);
        if (got !== exp) begin
            mismatchErrors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compareFlags(input flagVecT got, input flagVecT exp, input string what);
        if (got !== exp) begin
            mismatchErrors++;
            $display("mismatch at %0t: %s flags NZVC got %b expected %b",
                     $time, what, got, exp);
        end
    endtask

    function automatic wordT randWord();
        wordT w;
        w = '0;
        // fill 32 bits at a time so wider words are random throughout
        for (int i = 0; i < DATA_WIDTH; i += 32) begin
            w = (w << 32) | wordT'($urandom);
        end
        return w;
    endfunction

    // entered and left 2 ns after a rising edge
    task automatic issueOp(input aluOpT op, input wordT a, input wordT b);
        wordT    expWord;
        flagVecT expFlags;
        expectedOp(op, a, b, modelCarry, expWord, expFlags);
        expWordQ.push_back(expWord);
        expFlagQ.push_back(expFlags);
        issueCycQ.push_back(cycleCount);
        modelCarry = expFlags[FLAG_C];
        issuedOps++;
        opCode  = op;
        opA     = a;
        opB     = b;
        opValid = 1'b1;
        @(posedge clk);
        #2;
        opValid = 1'b0;
    endtask

    task automatic idleCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic clearFlags();
        flagsClear = 1'b1;
        modelCarry = 1'b0;
        @(posedge clk);
        #2;
        flagsClear = 1'b0;
        compareFlags({negative, zero, overflow, carry}, '0, "after flagsClear");
    endtask

    task automatic finishRun();
        $display("errors: mismatch %0d, protocol %0d, timeout %0d",
                 mismatchErrors, protocolErrors, timeoutErrors);
        if (mismatchErrors + protocolErrors + timeoutErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin : checkResults
        wordT    expWord;
        flagVecT expFlags;
        int      expCyc;
        if (arstN) begin
            if (resValid) begin
                if (expWordQ.size() == 0) begin
                    protocolErrors++;
                    $display("error at %0t: resValid seen with no operation pending", $time);
                end else begin
                    expWord  = expWordQ.pop_front();
                    expFlags = expFlagQ.pop_front();
                    expCyc   = issueCycQ.pop_front();
                    if (expCyc != cycleCount - 1) begin
                        protocolErrors++;
                        $display("error at %0t: result came %0d cycles after its strobe",
                                 $time, cycleCount - expCyc);
                    end
                    compareWord(result, expWord, "result");
                    compareFlags({negative, zero, overflow, carry}, expFlags, "result");
                end
            end else if (issueCycQ.size() != 0 && issueCycQ[0] < cycleCount) begin
                protocolErrors++;
                $display("error at %0t: no resValid one cycle after a strobe", $time);
                void'(expWordQ.pop_front());
                void'(expFlagQ.pop_front());
                void'(issueCycQ.pop_front());
            end
        end
    end

    // limit grows with the number of issued ops
    initial begin : watchdog
        @(posedge clk);
        while (cycleCount <= 2 * issuedOps + 100) begin
            @(posedge clk);
        end
        timeoutErrors++;
        $display("error: run did not finish within %0d cycles", cycleCount);
        finishRun();
    end

    initial begin
        wordT aLo;
        wordT bLo;
        int   idx;
        clk            = 1'b0;
        arstN          = 1'b0;
        opValid        = 1'b0;
        opCode         = OP_ADD;
        opA            = '0;
        opB            = '0;
        flagsClear     = 1'b0;
        modelCarry     = 1'b0;
        cycleCount     = 0;
        issuedOps      = 0;
        mismatchErrors = 0;
        protocolErrors = 0;
        timeoutErrors  = 0;
        void'($urandom(70132));
        opTable = '{OP_ADD, OP_ADC, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR};
        repeat (5) @(posedge clk);
        #2;
        arstN = 1'b1;
        idleCycle();

        // zero, all ones, signed extremes, one, and carries across each group edge
        cornerQ.push_back('0);
        cornerQ.push_back('1);
        cornerQ.push_back({1'b0, {(DATA_WIDTH-1){1'b1}}});
        cornerQ.push_back({1'b1, {(DATA_WIDTH-1){1'b0}}});
        cornerQ.push_back(wordT'(1));
        for (int k = 1; k < NUM_GROUPS; k++) begin
            cornerQ.push_back((wordT'(1) << (GROUP_WIDTH * k)) - wordT'(1));
        end
        foreach (cornerQ[i]) begin
            foreach (cornerQ[j]) begin
                issueOp(OP_ADD, cornerQ[i], cornerQ[j]);
                issueOp(OP_SUB, cornerQ[i], cornerQ[j]);
            end
        end

        // 64-bit adds split in two, low half forced to carry now and then
        for (int i = 0; i < 8; i++) begin
            aLo = (i % 2 == 0) ? '1 : randWord();
            bLo = (i % 2 == 0) ? wordT'(1) : randWord();
            issueOp(OP_ADD, aLo, bLo);
            issueOp(OP_ADC, randWord(), randWord());
            idleCycle();
        end
        issueOp(OP_ADD, '1, '1);
        repeat (3) issueOp(OP_ADC, '1, '0);
        // the clear must drop the carry that adc would consume
        issueOp(OP_ADD, '1, wordT'(1));
        clearFlags();
        issueOp(OP_ADC, '0, '0);

        // bitwise ops and every shift amount, upper bits of opB random
        for (int i = 0; i < 6; i++) begin
            issueOp(OP_AND, randWord(), randWord());
            issueOp(OP_OR, randWord(), randWord());
            issueOp(OP_XOR, randWord(), randWord());
        end
        for (int amt = 0; amt < DATA_WIDTH; amt++) begin
            bLo = randWord();
            bLo[SHIFT_WIDTH-1:0] = amt[SHIFT_WIDTH-1:0];
            aLo = randWord();
            issueOp(OP_SHL, aLo, bLo);
            issueOp(OP_SHR, aLo, bLo);
        end

        // random mix with gaps and the odd clear
        for (int i = 0; i < 400; i++) begin
            idx = $urandom % 8;
            if ($urandom % 4 == 0) begin
                aLo = cornerQ[$urandom % cornerQ.size()];
            end else begin
                aLo = randWord();
            end
            issueOp(opTable[idx], aLo, randWord());
            if ($urandom % 16 == 0) begin
                clearFlags();
            end else if ($urandom % 2 == 0) begin
                idleCycle();
            end
        end

        // let the last results drain, the watchdog bounds this wait
        while (issueCycQ.size() != 0) begin
            idleCycle();
        end
        repeat (3) idleCycle();
        finishRun();
    end

endmodule

//--- all.f
aluPkg.sv
flagPkg.sv
claGroup.sv
addSubUnit.sv
logicUnit.sv
resultStage.sv
statusReg.sv
aluTop.sv
tbAlu.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tbAlu
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
